//--- all.f
hw/tracker_pkg.sv
hw/line_expiry_tracker.sv
hw/sample_buffer.sv
hw/trace_controller.sv
hw/cache_trace_top.sv
test/tb_clock_gen.sv
test/tb_cache_trace.sv

//--- Makefile
TOP := tb_cache_trace

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module cache_trace_top
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- test/tb_cache_trace.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_trace
	import tracker_pkg::*;
();

	localparam int WAIT_LIMIT = 200;
	localparam int RUN_LIMIT = 5000;

	logic          clock;
	logic          resetn;
	logic          request;
	cache_access_t access;
	tracker_cfg_t  cfg;
	logic          stall;
	logic [31:0]   count;
	trace_record_t record;

	integer seed = 32'hc9a520e8;
	int     errors = 0;
	int     checks = 0;
	int     test_errors = 0;

	// reference model state
	// ----------------------------------------
	int            m_age [N_WAYS][N_LINES];
	int            m_sample_cnt;
	logic [31:0]   m_total;
	logic [31:0]   m_count;
	logic          m_stall;
	logic          m_pending;
	trace_record_t m_pending_rec;
	trace_record_t m_mem [BUFFER_DEPTH];

	tb_clock_gen clock_gen_i (
		.clock_o  (clock),
		.resetn_o (resetn)
	);

	cache_trace_top dut_i (
		.clock_i   (clock),
		.resetn_i  (resetn),
		.config_i  (cfg),
		.request_i (request),
		.access_i  (access),
		.stall_o   (stall),
		.count_o   (count),
		.record_o  (record)
	);

	// expired view of the model ages
	function automatic expired_vec_t expired_now();
		expired_vec_t v;
		for (int w = 0; w < N_WAYS; w++) begin
			for (int l = 0; l < N_LINES; l++) begin
				v[w][l] = (m_age[w][l] == EXPIRE_LIMIT);
			end
		end
		return v;
	endfunction

	// touched line to zero, the rest saturate upward
	function automatic void age_step(input cache_access_t a);
		for (int w = 0; w < N_WAYS; w++) begin
			for (int l = 0; l < N_LINES; l++) begin
				if (int'(a.way) == w && int'(a.line) == l) begin
					m_age[w][l] = 0;
				end else if (m_age[w][l] < EXPIRE_LIMIT) begin
					m_age[w][l]++;
				end
			end
		end
	endfunction

	// inputs seen here are the pre-edge values, same as the DUT
	always @(posedge clock) begin : ref_model
		logic accept;
		if (!resetn) begin
			for (int w = 0; w < N_WAYS; w++) begin
				for (int l = 0; l < N_LINES; l++) begin
					m_age[w][l] = 0;
				end
			end
			m_sample_cnt = 0;
			m_total = '0;
			m_count = '0;
			m_stall = 1'b0;
			m_pending = 1'b0;
		end else begin
			accept = request && cfg.enable && !m_stall;
			// a sample lands one edge after it is taken
			if (m_pending) begin
				m_mem[m_count[BW_BUFFER-1:0]] = m_pending_rec;
				m_count = m_count + 32'd1;
				if (m_count == 32'(BUFFER_DEPTH)) begin
					m_stall = 1'b1;
				end
			end
			m_pending = 1'b0;
			if (cfg.clear) begin
				m_count = '0;
				m_sample_cnt = 0;
				m_stall = 1'b0;
			end
			if (accept) begin
				// total keeps running through a clear
				m_total = m_total + 32'd1;
				if (!cfg.clear && m_sample_cnt == SAMPLE_PERIOD - 1) begin
					m_pending_rec.expired = expired_now();
					m_pending_rec.access_count = m_total;
					m_pending = 1'b1;
					m_sample_cnt = 0;
				end else if (!cfg.clear) begin
					m_sample_cnt++;
				end
				age_step(access);
			end
		end
	end

	// helpers
	// ----------------------------------------
	function automatic cache_access_t random_access();
		logic [31:0]   r;
		cache_access_t a;
		r = $random(seed);
		a.way = BW_WAY'(r[15:0] % 16'd3);
		a.line = BW_LINE'(r >> 16);
		return a;
	endfunction

	task automatic check_u32(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_record(input trace_record_t got, input trace_record_t exp, input int addr);
		checks++;
		assert (got.expired === exp.expired) else begin
			$display("Error at %0t ns: expired bits at address %0d are %h, expected %h",
				$time, addr, got.expired, exp.expired);
			errors++;
		end
		checks++;
		assert (got.access_count === exp.access_count) else begin
			$display("Error at %0t ns: access_count at address %0d is %0d, expected %0d",
				$time, addr, got.access_count, exp.access_count);
			errors++;
		end
	endtask

	// n request cycles, idle cycles mixed in when gaps is set
	task automatic drive_accesses(input int n, input bit gaps);
		logic [31:0] r;
		int          sent;
		sent = 0;
		while (sent < n) begin
			@(posedge clock);
			r = $random(seed);
			if (gaps && r[4]) begin
				request <= 1'b0;
			end else begin
				request <= 1'b1;
				access <= random_access();
				sent++;
			end
		end
		@(posedge clock);
		request <= 1'b0;
		@(negedge clock);
	endtask

	task automatic wait_for_count(input logic [31:0] target);
		int cycles;
		cycles = 0;
		while (count !== target && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (count === target) else begin
			$display("Timeout: count_o never reached %0d", target);
			errors++;
		end
	endtask

	task automatic wait_for_stall(input logic level);
		int cycles;
		cycles = 0;
		while (stall !== level && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (stall === level) else begin
			$display("Timeout: stall_o never went to %0b", level);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// stimulus
	// ----------------------------------------
	initial begin : stimulus
		int          cycles;
		int          expired_seen;
		logic [31:0] pre_clear_total;
		request = 1'b0;
		access = '0;
		cfg = '0;
		cycles = 0;
		while (resetn !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		assert (resetn === 1'b1) else begin
			$display("Timeout: reset was never released");
			errors++;
		end
		@(negedge clock);

		// idle after reset, tracking off
		check_u32({31'd0, stall}, 32'd0, "stall_o after reset");
		check_u32(count, 32'd0, "count_o after reset");
		drive_accesses(2 * SAMPLE_PERIOD, 1'b1);
		repeat (3) @(negedge clock);
		check_u32(count, 32'd0, "count_o with enable low");
		end_test("disabled");

		// one record per SAMPLE_PERIOD accepted requests
		@(posedge clock);
		cfg.enable <= 1'b1;
		for (int k = 1; k <= 4; k++) begin
			drive_accesses(SAMPLE_PERIOD, 1'b1);
			wait_for_count(32'(k));
			check_u32(count, m_count, "count_o against model");
		end
		end_test("sampling");

		// back-to-back requests until the buffer is full
		cycles = 0;
		while (!stall && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			request <= 1'b1;
			access <= random_access();
			@(negedge clock);
			cycles++;
		end
		assert (stall) else begin
			$display("Timeout: stall_o never rose while filling the buffer");
			errors++;
		end
		check_u32(count, 32'(BUFFER_DEPTH), "count_o when full");
		// these must all be dropped
		drive_accesses(2 * SAMPLE_PERIOD, 1'b0);
		check_u32(count, 32'(BUFFER_DEPTH), "count_o during stall");
		check_u32({31'd0, stall}, 32'd1, "stall_o during stall");
		end_test("fill");

		// host read, two edges from read_addr to record_o
		expired_seen = 0;
		for (int a = 0; a < BUFFER_DEPTH; a++) begin
			@(posedge clock);
			cfg.read_addr <= 5'(a);
			repeat (2) @(posedge clock);
			@(negedge clock);
			check_record(record, m_mem[a], a);
			check_u32(record.access_count, 32'(SAMPLE_PERIOD * (a + 1)), "access_count");
			expired_seen += $countones(m_mem[a].expired);
		end
		assert (expired_seen > 0) else begin
			$display("Failed: no stored record held a saturated line");
			errors++;
		end
		end_test("readback");

		// clear pulse, then one fresh sample at address zero
		pre_clear_total = m_total;
		@(posedge clock);
		cfg.clear <= 1'b1;
		@(posedge clock);
		cfg.clear <= 1'b0;
		@(negedge clock);
		wait_for_stall(1'b0);
		check_u32(count, 32'd0, "count_o after clear");
		drive_accesses(SAMPLE_PERIOD, 1'b1);
		wait_for_count(32'd1);
		@(posedge clock);
		cfg.enable <= 1'b0;
		cfg.read_addr <= '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		check_record(record, m_mem[0], 0);
		check_u32(record.access_count, pre_clear_total + 32'(SAMPLE_PERIOD),
			"access_count after clear");
		end_test("clear");

		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// hard stop on a hung run
	initial begin : watchdog
		repeat (RUN_LIMIT) @(posedge clock);
		$display("Run limit of %0d cycles reached before the tests finished", RUN_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clock_o,
	output logic resetn_o
);

	// 4 ns period
	initial begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o;
	end

	// reset held low over the first two rising edges
	initial begin
		resetn_o = 1'b0;
		repeat (2) @(posedge clock_o);
		resetn_o <= 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/cache_trace_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_trace_top
	import tracker_pkg::*;
(
	input  wire                clock_i,
	input  wire                resetn_i,
	input  wire tracker_cfg_t  config_i,
	input  wire                request_i,
	input  wire cache_access_t access_i,
	output logic               stall_o,
	output logic [31:0]        count_o,
	output trace_record_t      record_o
);

	// internal nets
	// ----------------------------------------
	logic                 access_valid;
	expired_vec_t         expired;
	logic                 buf_wr_en;
	logic [BW_BUFFER-1:0] buf_addr;
	trace_record_t        buf_wr_data;
	trace_record_t        buf_rd_data;

	// sampling, stall and port arbitration
	trace_controller trace_controller_i (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.config_i       (config_i),
		.request_i      (request_i),
		.expired_i      (expired),
		.access_valid_o (access_valid),
		.stall_o        (stall_o),
		.count_o        (count_o),
		.buf_wr_en_o    (buf_wr_en),
		.buf_addr_o     (buf_addr),
		.buf_wr_data_o  (buf_wr_data),
		.buf_rd_data_i  (buf_rd_data),
		.record_o       (record_o)
	);

	// ages only move on accepted accesses
	line_expiry_tracker line_expiry_tracker_i (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.access_valid_i (access_valid),
		.access_i       (access_i),
		.expired_o      (expired)
	);

	// record memory
	sample_buffer sample_buffer_i (
		.clock_i   (clock_i),
		.wr_en_i   (buf_wr_en),
		.addr_i    (buf_addr),
		.wr_data_i (buf_wr_data),
		.rd_data_o (buf_rd_data)
	);

endmodule

`default_nettype wire

//--- hw/trace_controller.sv
`timescale 1ns/10ps
`default_nettype none

module trace_controller
	import tracker_pkg::*;
(
	input  wire                  clock_i,
	input  wire                  resetn_i,
	input  wire tracker_cfg_t    config_i,
	input  wire                  request_i,
	input  wire expired_vec_t    expired_i,

	output logic                 access_valid_o,
	output logic                 stall_o,
	output logic [31:0]          count_o,

	// buffer side
	output logic                 buf_wr_en_o,
	output logic [BW_BUFFER-1:0] buf_addr_o,
	output trace_record_t        buf_wr_data_o,
	input  wire trace_record_t   buf_rd_data_i,

	output trace_record_t        record_o
);

	// state
	// ----------------------------------------
	logic                 stall_q;
	logic [31:0]          count_q;
	logic [31:0]          count_d;
	logic [BW_SAMPLE-1:0] sample_cnt_q;
	logic [31:0]          access_total_q;
	logic                 wr_en_q;
	logic [BW_BUFFER-1:0] addr_q;
	trace_record_t        wr_data_q;

	logic                 accept;
	logic                 sample_hit;
	logic                 host_owns_addr;

	localparam logic [BW_SAMPLE-1:0] SAMPLE_LAST = BW_SAMPLE'(SAMPLE_PERIOD - 1);

	// request qualification
	// ----------------------------------------
	// requests during a stall are dropped, not queued
	assign accept = request_i && config_i.enable && !stall_q;

	// last access of the period, unless a clear restarts the count
	assign sample_hit = accept && (sample_cnt_q == SAMPLE_LAST) && !config_i.clear;

	// host gets the port when tracking is off, or full with nothing left to land
	assign host_owns_addr = !config_i.enable || (stall_q && !wr_en_q);

	// record count after this edge
	assign count_d = config_i.clear ? 32'd0 : (count_q + {31'd0, wr_en_q});

	// control
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			stall_q <= 1'b0;
			count_q <= '0;
			sample_cnt_q <= '0;
			access_total_q <= '0;
			wr_en_q <= 1'b0;
			addr_q <= '0;
		end else begin
			count_q <= count_d;

			// running total survives a clear
			if (accept) begin
				access_total_q <= access_total_q + 32'd1;
			end

			// sample period counter
			if (config_i.clear || sample_hit) begin
				sample_cnt_q <= '0;
			end else if (accept) begin
				sample_cnt_q <= sample_cnt_q + 1'b1;
			end

			// full stall rises on the write that fills the buffer
			if (config_i.clear) begin
				stall_q <= 1'b0;
			end else if (wr_en_q && (count_q + 32'd1 == 32'(BUFFER_DEPTH))) begin
				stall_q <= 1'b1;
			end

			// buffer port arbitration
			wr_en_q <= sample_hit;
			if (sample_hit) begin
				addr_q <= count_d[BW_BUFFER-1:0];
			end else if (host_owns_addr) begin
				addr_q <= config_i.read_addr[BW_BUFFER-1:0];
			end
		end
	end

	// record payload
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (sample_hit) begin
			// expired as it stood before this access
			wr_data_q.expired <= expired_i;
			// total includes the access that triggered the sample
			wr_data_q.access_count <= access_total_q + 32'd1;
		end
	end

	// outputs
	// ----------------------------------------
	assign access_valid_o = accept;
	assign stall_o = stall_q;
	assign count_o = count_q;
	assign buf_wr_en_o = wr_en_q;
	assign buf_addr_o = addr_q;
	assign buf_wr_data_o = wr_data_q;
	// read data already registered in the buffer
	assign record_o = buf_rd_data_i;

endmodule

`default_nettype wire

//--- hw/sample_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module sample_buffer
	import tracker_pkg::*;
(
	input  wire                 clock_i,
	input  wire                 wr_en_i,
	input  wire [BW_BUFFER-1:0] addr_i,
	input  wire trace_record_t  wr_data_i,
	output trace_record_t       rd_data_o
);

	// record storage
	// ----------------------------------------
	trace_record_t mem [BUFFER_DEPTH];
	trace_record_t rd_data_q;

	// single port, read-first
	always_ff @(posedge clock_i) begin
		if (wr_en_i) begin
			mem[addr_i] <= wr_data_i;
		end
		// old contents come out on a write cycle
		rd_data_q <= mem[addr_i];
	end

	assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hw/line_expiry_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module line_expiry_tracker
	import tracker_pkg::*;
(
	input  wire                clock_i,
	input  wire                resetn_i,
	// already qualified by enable and not-stalled
	input  wire                access_valid_i,
	input  wire cache_access_t access_i,
	output expired_vec_t       expired_o
);

	// age state
	// ----------------------------------------
	logic [N_WAYS-1:0][N_LINES-1:0][BW_AGE-1:0] age_q;
	logic [N_WAYS-1:0][N_LINES-1:0][BW_AGE-1:0] age_d;
	expired_vec_t                               expired_q;
	expired_vec_t                               expired_d;

	localparam logic [BW_AGE-1:0] AGE_MAX = BW_AGE'(EXPIRE_LIMIT);

	// next ages
	// ----------------------------------------
	always_comb begin
		logic hit;
		for (int w = 0; w < N_WAYS; w++) begin
			for (int l = 0; l < N_LINES; l++) begin
				hit = (access_i.way == BW_WAY'(w)) && (access_i.line == BW_LINE'(l));
				// hold by default
				age_d[w][l] = age_q[w][l];
				if (access_valid_i) begin
					if (hit) begin
						// touched line starts over
						age_d[w][l] = '0;
					end else if (age_q[w][l] != AGE_MAX) begin
						// everyone else ages, saturating
						age_d[w][l] = age_q[w][l] + 1'b1;
					end
				end
				// expired flag tracks the new age
				expired_d[w][l] = (age_d[w][l] == AGE_MAX);
			end
		end
	end

	// state update
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			age_q <= '0;
			expired_q <= '0;
		end else begin
			age_q <= age_d;
			// registered alongside the ages, so it always matches them
			expired_q <= expired_d;
		end
	end

	// vector seen by the controller is pre-update at any accepting edge
	assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- hw/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

	// tracked geometry
	// ----------------------------------------
	localparam int N_WAYS = 3;
	localparam int N_LINES = 16;
	localparam int BW_WAY = 2;
	localparam int BW_LINE = $clog2(N_LINES);

	// ages count accesses, not cycles
	localparam int EXPIRE_LIMIT = 6;
	localparam int BW_AGE = $clog2(EXPIRE_LIMIT + 1);

	// sampling and record storage
	// ----------------------------------------
	localparam int SAMPLE_PERIOD = 4;
	localparam int BW_SAMPLE = $clog2(SAMPLE_PERIOD);
	localparam int BUFFER_DEPTH = 16;
	localparam int BW_BUFFER = $clog2(BUFFER_DEPTH);

	// one access reported by the cache controller
	typedef struct packed {
		logic [BW_WAY-1:0]  way;
		logic [BW_LINE-1:0] line;
	} cache_access_t;

	// host config word, msb first
	typedef struct packed {
		logic [6:0]  rsvd_hi;
		logic        enable;
		logic        clear;
		logic [12:0] rsvd_mid;
		// only the low BW_BUFFER bits reach the buffer
		logic [4:0]  read_addr;
		logic [4:0]  rsvd_lo;
	} tracker_cfg_t;

	// expired bits, one bank per way
	typedef logic [N_WAYS-1:0][N_LINES-1:0] expired_vec_t;

	// one stored sample, 80 bits
	typedef struct packed {
		expired_vec_t expired;
		logic [31:0]  access_count;
	} trace_record_t;

endpackage

`default_nettype wire
